/* list.f */
+incdir+rtl
+incdir+test
rtl/coco_bus_pkg.sv
rtl/bus_decode.sv
rtl/mem_bank.sv
rtl/pia_port_b.sv
rtl/read_mux.sv
rtl/coco_bus_top.sv
test/tb_coco_bus.sv

/* run.sh */
#!/bin/bash
# build the coco bus testbench with verilator, run it, then scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_coco_bus -o sim_coco_bus
./obj_dir/sim_coco_bus | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation finished clean"

/* test/tb_coco_bus_table.svh */
// step table for the coco bus testbench, applied one bus cycle per entry after the rom download
// columns are mode (1 is dragon 64), kind, address, data
// data is the write byte, the expected read byte or, for rom reads, the download index

localparam int num_steps = 39;

step_t steps [0:num_steps-1] = '{
  '{1'b0, k_port,     16'h0000, 8'h00},                // port_b after reset
  '{1'b0, k_idle,     16'h0000, 8'h00},
  '{1'b0, k_wr_rnd,   16'h0000, 8'h00},                // ram, lcg bytes
  '{1'b0, k_wr_rnd,   16'h7fff, 8'h00},
  '{1'b0, k_rd_ram,   16'h0000, 8'h00},                // two reads in flight
  '{1'b0, k_rd_ram,   16'h7fff, 8'h00},
  '{1'b0, k_wr_rnd,   16'h2a2a, 8'h00},
  '{1'b0, k_rd_ram,   16'h2a2a, 8'h00},                // read right behind its write
  '{1'b0, k_rd_rom,   16'h8000, 8'(`COCO_LOAD_BANK1)},  // extended basic
  '{1'b0, k_rd_rom,   16'hbfff, 8'(`COCO_LOAD_BANK1)},  // colour basic
  '{1'b0, k_rd_rom,   16'hc000, 8'(`COCO_LOAD_CART)},
  '{1'b0, k_rd_rom,   16'hfeff, 8'(`COCO_LOAD_CART)},   // last cartridge byte
  '{1'b0, k_rd,       16'hff1f, `COCO_UNMAPPED_DATA},  // pia0
  '{1'b0, k_rd,       16'hff40, `COCO_UNMAPPED_DATA},  // disk i/o
  '{1'b0, k_rd,       16'hffff, `COCO_UNMAPPED_DATA},
  // pia1 port b, coco pins all low
  '{1'b0, k_rd,       16'hff22, 8'h00},                // ddr out of reset
  '{1'b0, k_wr,       16'hff22, 8'hf4},                // ddr
  '{1'b0, k_rd,       16'hff22, 8'hf4},
  '{1'b0, k_wr,       16'hff23, 8'h04},                // control bit 2 on
  '{1'b0, k_wr,       16'hff22, 8'ha1},                // output register
  '{1'b0, k_port,     16'h0000, 8'ha1},
  '{1'b0, k_rd,       16'hff3e, 8'ha0},                // mirror, outputs where ddr is 1
  '{1'b0, k_wr,       16'hff2b, 8'h00},                // mirror of control
  '{1'b0, k_rd,       16'hff26, 8'hf4},                // ddr again through a mirror
  '{1'b0, k_rd_rom,   16'ha000, 8'(`COCO_LOAD_BANK1)},  // bank line high, coco ignores it
  // dragon 64
  '{1'b1, k_wr,       16'hff23, 8'h04},
  '{1'b1, k_rd,       16'hff22, 8'ha1},                // pin 0 shows through
  '{1'b1, k_rd_rom,   16'h8000, 8'(`COCO_LOAD_BANK2)},
  '{1'b1, k_rd_rom,   16'hbfff, 8'(`COCO_LOAD_BANK2)},
  '{1'b1, k_wr,       16'hff22, 8'ha5},                // output bit 2 set, back to bank 1
  '{1'b1, k_rd_rom,   16'h9abc, 8'(`COCO_LOAD_BANK1)},
  '{1'b1, k_wr,       16'hff22, 8'ha1},
  '{1'b1, k_rd_rom,   16'ha000, 8'(`COCO_LOAD_BANK2)},  // bank flips for the very next read
  '{1'b1, k_rd,       16'hff04, `COCO_ACIA_STATUS},
  '{1'b1, k_rd,       16'hff1f, `COCO_ACIA_STATUS},    // top quad of the window
  '{1'b1, k_rd,       16'hff03, `COCO_UNMAPPED_DATA},
  // back to coco
  '{1'b0, k_rd,       16'hff04, `COCO_UNMAPPED_DATA},  // no acia here
  '{1'b0, k_rd_rom,   16'h8000, 8'(`COCO_LOAD_BANK1)},
  '{1'b0, k_idle,     16'h0000, 8'h00}
};

/* test/tb_coco_bus.sv */
// testbench for coco_bus_top, downloads the roms, runs the step table and checks every read
`timescale 1ns/1ns
`default_nettype none

`include "coco_bus_cfg.svh"

module tb_coco_bus;

  localparam logic [2:0] k_idle   = 3'd0;  // no request
  localparam logic [2:0] k_port   = 3'd1;  // compare port_b with data
  localparam logic [2:0] k_wr     = 3'd2;
  localparam logic [2:0] k_wr_rnd = 3'd3;  // ram write of the next lcg byte
  localparam logic [2:0] k_rd     = 3'd4;  // data is the expected byte
  localparam logic [2:0] k_rd_ram = 3'd5;  // expect what the table wrote there
  localparam logic [2:0] k_rd_rom = 3'd6;  // data is the download index

  typedef struct packed {
    logic                mode;
    logic [2:0]          kind;
    coco_bus_pkg::addr_t addr;
    coco_bus_pkg::data_t data;
  } step_t;

  logic                    clk;
  logic                    reset_n;
  logic                    dragon64;
  logic                    bus_valid;
  coco_bus_pkg::addr_t     bus_addr;
  logic                    bus_rw;
  coco_bus_pkg::data_t     bus_wdata;
  logic                    load_wr;
  coco_bus_pkg::load_idx_t load_idx;
  coco_bus_pkg::rom_addr_t load_addr;
  coco_bus_pkg::data_t     load_data;
  logic                    rd_valid;
  coco_bus_pkg::data_t     rd_data;
  coco_bus_pkg::data_t     port_b;

  `include "tb_coco_bus_table.svh"

  coco_bus_pkg::data_t ram_seen [0:(1 << `COCO_RAM_AW)-1];  // last byte written per address
  coco_bus_pkg::data_t exp_q [$];   // reads in flight, oldest first
  coco_bus_pkg::addr_t addr_q [$];
  int                  cyc_q [$];   // cycle each read was driven
  int                  cycle = 0;
  int                  data_errors = 0;
  int                  port_errors = 0;
  int                  timing_errors = 0;
  logic [31:0]         lcg_state;

  coco_bus_top coco_bus_top_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .dragon64  (dragon64),
    .bus_valid (bus_valid),
    .bus_addr  (bus_addr),
    .bus_rw    (bus_rw),
    .bus_wdata (bus_wdata),
    .load_wr   (load_wr),
    .load_idx  (load_idx),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .port_b    (port_b)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // download pattern, every offset bit and the index reach the byte
  function automatic coco_bus_pkg::data_t rom_byte(input int idx, input int off);
    return coco_bus_pkg::data_t'(off ^ ((off >> 8) * 3 + idx * 85 + 17));
  endfunction

  task automatic check_data(input coco_bus_pkg::addr_t addr, input coco_bus_pkg::data_t got,
                            input coco_bus_pkg::data_t exp);
    if (got !== exp)
    begin
      data_errors++;
      $display("Error rd_data for read of %h: got %h, expected %h", addr, got, exp);
    end
  endtask

  task automatic check_port(input coco_bus_pkg::data_t got, input coco_bus_pkg::data_t exp);
    if (got !== exp)
    begin
      port_errors++;
      $display("Error port_b: got %h, expected %h", got, exp);
    end
  endtask

  // drive one table entry and queue the byte a read should bring back
  task automatic apply_step(input step_t s);
    coco_bus_pkg::data_t exp;
    exp       = s.data;
    dragon64  = s.mode;
    bus_valid = (s.kind != k_idle) && (s.kind != k_port);
    bus_addr  = s.addr;
    bus_rw    = (s.kind >= k_rd);
    bus_wdata = s.data;
    case (s.kind)
      k_port:   check_port(port_b, s.data);
      k_wr_rnd:
      begin
        lcg_state = lcg_next(lcg_state);
        bus_wdata = lcg_state[23:16];  // upper bits, low ones repeat too soon
        ram_seen[s.addr[`COCO_RAM_AW-1:0]] = bus_wdata;
      end
      k_rd_ram: exp = ram_seen[s.addr[`COCO_RAM_AW-1:0]];
      k_rd_rom:
      begin
        if (s.data == 8'(`COCO_LOAD_CART))
          exp = rom_byte(int'(s.data), int'(s.addr - `COCO_CART_BASE));
        else
          exp = rom_byte(int'(s.data), int'(s.addr - `COCO_ROM_BASE));  // both basic windows
      end
      default: ;
    endcase
    if (bus_valid && bus_rw)
    begin
      exp_q.push_back(exp);
      addr_q.push_back(s.addr);
      cyc_q.push_back(cycle);
    end
  endtask

  // results sampled mid cycle, each read owes one rd_valid exactly two cycles on
  always @(negedge clk)
  begin
    if (rd_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        timing_errors++;
        $display("rd_valid went high with no read outstanding, cycle %0d", cycle);
      end
      else
      begin
        if (cycle != cyc_q[0] + `COCO_READ_LATENCY)
        begin
          timing_errors++;
          $display("read of %h returned after %0d cycles", addr_q[0], cycle - cyc_q[0]);
        end
        check_data(addr_q.pop_front(), rd_data, exp_q.pop_front());
        void'(cyc_q.pop_front());
      end
    end
    else if (exp_q.size() != 0 && cycle >= cyc_q[0] + `COCO_READ_LATENCY)
    begin
      timing_errors++;
      $display("no rd_valid for the read of %h driven at cycle %0d", addr_q[0], cyc_q[0]);
      void'(exp_q.pop_front());
      void'(addr_q.pop_front());
      void'(cyc_q.pop_front());
    end
  end

  initial
  begin
    lcg_state = 32'h4fab;
    reset_n   = 1'b0;
    dragon64  = 1'b0;
    bus_valid = 1'b0;
    bus_addr  = '0;
    bus_rw    = 1'b1;
    bus_wdata = '0;
    load_wr   = 1'b0;
    load_idx  = '0;
    load_addr = '0;
    load_data = '0;
    repeat (4) @(posedge clk);
    #2;
    reset_n = 1'b1;

    // bank 1, bank 2, then the cartridge, one byte per cycle
    for (int idx = 0; idx < 3; idx++)
      for (int off = 0; off < (1 << `COCO_ROM_AW); off++)
      begin
        @(posedge clk);
        #2;
        load_wr   = 1'b1;
        load_idx  = coco_bus_pkg::load_idx_t'(idx);
        load_addr = coco_bus_pkg::rom_addr_t'(off);
        load_data = rom_byte(idx, off);
      end
    @(posedge clk);
    #2;
    load_wr = 1'b0;

    foreach (steps[i])
    begin
      @(posedge clk);
      #2;
      apply_step(steps[i]);
    end
    @(posedge clk);
    #2;
    bus_valid = 1'b0;

    for (int t = 0; t < 20 && exp_q.size() != 0; t++)  // drain
      @(posedge clk);
    if (exp_q.size() != 0)
    begin
      timing_errors++;
      $display("timed out with %0d reads still outstanding", exp_q.size());
    end
    repeat (`COCO_READ_LATENCY + 2) @(posedge clk);  // room for a stray rd_valid

    $display("errors: data %0d, port %0d, timing %0d", data_errors, port_errors, timing_errors);
    if (data_errors + port_errors + timing_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/coco_bus_top.sv */
// top level of the coco / dragon cpu bus, decode plus memories plus pia1 port b plus read path
`timescale 1ns/1ns
`default_nettype none

module coco_bus_top (
  input  wire logic                     clk,
  input  wire logic                     reset_n,
  input  wire logic                     dragon64,   // static, selects the dragon 64 map

  // one request per cycle, no back-pressure
  input  wire logic                     bus_valid,
  input  wire coco_bus_pkg::addr_t      bus_addr,
  input  wire logic                     bus_rw,     // 1 is read
  input  wire coco_bus_pkg::data_t      bus_wdata,

  // rom and cartridge download
  input  wire logic                     load_wr,
  input  wire coco_bus_pkg::load_idx_t  load_idx,
  input  wire coco_bus_pkg::rom_addr_t  load_addr,
  input  wire coco_bus_pkg::data_t      load_data,

  // read result, two cycles after the request
  output logic                          rd_valid,
  output coco_bus_pkg::data_t           rd_data,
  output coco_bus_pkg::data_t           port_b      // pia1 port b output register
);

  coco_bus_pkg::dev_sel_t  dev_sel;
  logic                    rom_bank;
  logic                    rom_bank_sel;   // pia1 line, before the mode gate
  coco_bus_pkg::ram_addr_t ram_addr;
  coco_bus_pkg::rom_addr_t rom_addr;
  coco_bus_pkg::data_t     mem_rdata;
  coco_bus_pkg::data_t     pia_rdata;

  bus_decode bus_decode_inst (
    .dragon64     (dragon64),
    .bus_addr     (bus_addr),
    .rom_bank_sel (rom_bank_sel),
    .dev_sel      (dev_sel),
    .rom_bank     (rom_bank),
    .ram_addr     (ram_addr),
    .rom_addr     (rom_addr)
  );

  mem_bank mem_bank_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_valid (bus_valid),
    .bus_rw    (bus_rw),
    .bus_wdata (bus_wdata),
    .dev_sel   (dev_sel),
    .ram_addr  (ram_addr),
    .rom_addr  (rom_addr),
    .rom_bank  (rom_bank),
    .load_wr   (load_wr),
    .load_idx  (load_idx),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem_rdata (mem_rdata)
  );

  // window mirrors every four bytes, only the low two address bits go in
  pia_port_b pia_port_b_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .dragon64     (dragon64),
    .bus_valid    (bus_valid),
    .bus_rw       (bus_rw),
    .bus_wdata    (bus_wdata),
    .bus_addr_lo  (bus_addr[1:0]),
    .dev_sel      (dev_sel),
    .pia_rdata    (pia_rdata),
    .port_b       (port_b),
    .rom_bank_sel (rom_bank_sel)
  );

  read_mux read_mux_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_valid (bus_valid),
    .bus_rw    (bus_rw),
    .dev_sel   (dev_sel),
    .mem_rdata (mem_rdata),
    .pia_rdata (pia_rdata),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

/* rtl/read_mux.sv */
// result stage, lines up the device select with the array data and registers the read byte
`timescale 1ns/1ns
`default_nettype none

`include "coco_bus_cfg.svh"

module read_mux (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  input  wire logic                    bus_valid,
  input  wire logic                    bus_rw,
  input  wire coco_bus_pkg::dev_sel_t  dev_sel,
  input  wire coco_bus_pkg::data_t     mem_rdata,   // registered in mem_bank
  input  wire coco_bus_pkg::data_t     pia_rdata,   // registered in pia_port_b
  output logic                         rd_valid,
  output coco_bus_pkg::data_t          rd_data
);

  logic                   rd_pend;  // read in flight, first stage
  coco_bus_pkg::dev_sel_t rd_sel;   // its device, same age as mem_rdata

  // stage 1, same edge the arrays capture their byte
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      rd_pend <= 1'b0;
    else
      rd_pend <= bus_valid & bus_rw;  // writes never enter the pipe
  end

  always_ff @(posedge clk)
  begin
    rd_sel <= dev_sel;
  end

  // stage 2
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= rd_pend;
  end

  always_ff @(posedge clk)
  begin
    if (rd_pend)
    begin
      case (rd_sel)
        coco_bus_pkg::dev_ram,
        coco_bus_pkg::dev_rom,
        coco_bus_pkg::dev_cart: rd_data <= mem_rdata;
        coco_bus_pkg::dev_pia1: rd_data <= pia_rdata;
        coco_bus_pkg::dev_acia: rd_data <= `COCO_ACIA_STATUS;  // stub, same at every register
        default:                rd_data <= `COCO_UNMAPPED_DATA; // pia0, disk i/o, unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/pia_port_b.sv */
// pia1 port b registers, with the readback rules and the dragon 64 rom bank line
`timescale 1ns/1ns
`default_nettype none

`include "coco_bus_cfg.svh"

module pia_port_b (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  input  wire logic                    dragon64,
  input  wire logic                    bus_valid,
  input  wire logic                    bus_rw,
  input  wire coco_bus_pkg::data_t     bus_wdata,
  input  wire logic [1:0]              bus_addr_lo,  // register within the mirrored quad
  input  wire coco_bus_pkg::dev_sel_t  dev_sel,
  output coco_bus_pkg::data_t          pia_rdata,
  output coco_bus_pkg::data_t          port_b,       // output register, video mode and sound
  output logic                         rom_bank_sel
);

  coco_bus_pkg::data_t ddrb;
  logic [5:0]          crb;      // irq flags in bits 7:6 dropped, read as 0
  coco_bus_pkg::data_t pins;     // port b input pins
  coco_bus_pkg::data_t rd_byte;
  logic                hit_wr;

  assign hit_wr = bus_valid & ~bus_rw & (dev_sel == coco_bus_pkg::dev_pia1);
  assign pins   = dragon64 ? `COCO_PORTB_IN_D64 : 8'h00;

  // crb bit 2 steers offset 2 between ddr and output register
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ddrb   <= 8'h00;
      port_b <= 8'h00;
      crb    <= 6'h00;
    end
    else if (hit_wr)
    begin
      case (bus_addr_lo)
        2'd2:
        begin
          if (crb[2])
            port_b <= bus_wdata;
          else
            ddrb <= bus_wdata;
        end
        2'd3:    crb <= bus_wdata[5:0];
        default: ;                               // port a, nothing behind it
      endcase
    end
  end

  always_comb
  begin
    case (bus_addr_lo)
      2'd2:    rd_byte = crb[2] ? ((port_b & ddrb) | (pins & ~ddrb)) : ddrb;
      2'd3:    rd_byte = {2'b00, crb};
      default: rd_byte = `COCO_UNMAPPED_DATA;    // port a dropped
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (bus_valid && bus_rw)
      pia_rdata <= rd_byte;  // read_mux only takes it for dev_pia1
  end

  // pin 2 floats high through a resistor unless driven low as an output
  assign rom_bank_sel = ddrb[2] & ~port_b[2];

endmodule

`default_nettype wire

/* rtl/mem_bank.sv */
// ram, two basic rom banks and the cartridge, with the cpu port and the download port
`timescale 1ns/1ns
`default_nettype none

`include "coco_bus_cfg.svh"

module mem_bank (
  input  wire logic                     clk,
  input  wire logic                     reset_n,
  input  wire logic                     bus_valid,
  input  wire logic                     bus_rw,     // 1 is read
  input  wire coco_bus_pkg::data_t      bus_wdata,
  input  wire coco_bus_pkg::dev_sel_t   dev_sel,
  input  wire coco_bus_pkg::ram_addr_t  ram_addr,
  input  wire coco_bus_pkg::rom_addr_t  rom_addr,
  input  wire logic                     rom_bank,
  input  wire logic                     load_wr,
  input  wire coco_bus_pkg::load_idx_t  load_idx,
  input  wire coco_bus_pkg::rom_addr_t  load_addr,
  input  wire coco_bus_pkg::data_t      load_data,
  output coco_bus_pkg::data_t           mem_rdata
);

  localparam int RAM_DEPTH = 1 << `COCO_RAM_AW;
  localparam int ROM_DEPTH = 1 << `COCO_ROM_AW;

  coco_bus_pkg::data_t ram       [0:RAM_DEPTH-1];  // 32k
  coco_bus_pkg::data_t rom_bank1 [0:ROM_DEPTH-1];  // coco basic, or dragon 64 first bank
  coco_bus_pkg::data_t rom_bank2 [0:ROM_DEPTH-1];  // dragon 64 alternate bank
  coco_bus_pkg::data_t cart      [0:ROM_DEPTH-1];  // map only reaches offsets up to 3eff

  logic cpu_rd;
  logic cpu_ram_wr;

  assign cpu_rd     = bus_valid & bus_rw;
  assign cpu_ram_wr = bus_valid & ~bus_rw & (dev_sel == coco_bus_pkg::dev_ram);

  // cpu can only write ram, writes to rom and cart are dropped
  always_ff @(posedge clk)
  begin
    if (cpu_ram_wr)
      ram[ram_addr] <= bus_wdata;
  end

  // download side, one always block per array keeps each a plain single port write
  always_ff @(posedge clk)
  begin
    if (load_wr && load_idx == `COCO_LOAD_BANK1)
      rom_bank1[load_addr] <= load_data;
  end

  always_ff @(posedge clk)
  begin
    if (load_wr && load_idx == `COCO_LOAD_BANK2)
      rom_bank2[load_addr] <= load_data;
  end

  always_ff @(posedge clk)
  begin
    if (load_wr && load_idx == `COCO_LOAD_CART)
      cart[load_addr] <= load_data;
  end

  // registered read, first half of the two cycle read path
  always_ff @(posedge clk)
  begin
    if (cpu_rd)
    begin
      case (dev_sel)
        coco_bus_pkg::dev_ram:  mem_rdata <= ram[ram_addr];
        coco_bus_pkg::dev_rom:
        begin
          if (rom_bank)
            mem_rdata <= rom_bank2[rom_addr];
          else
            mem_rdata <= rom_bank1[rom_addr];
        end
        coco_bus_pkg::dev_cart: mem_rdata <= cart[rom_addr];
        default:                mem_rdata <= `COCO_UNMAPPED_DATA;  // not an array, read_mux picks
      endcase
    end
  end

  // only three download targets exist
  a_load_idx_known: assert property (
    @(posedge clk) disable iff (!reset_n)
    load_wr |-> (load_idx == `COCO_LOAD_BANK1 ||
                 load_idx == `COCO_LOAD_BANK2 ||
                 load_idx == `COCO_LOAD_CART))
    else $error("download write with undefined index %0d", load_idx);

  // download and cpu never meet on one array in the same cycle
  a_no_load_clash: assert property (
    @(posedge clk) disable iff (!reset_n)
    (load_wr && bus_valid) |->
      !(dev_sel == coco_bus_pkg::dev_rom &&
        load_idx == (rom_bank ? `COCO_LOAD_BANK2 : `COCO_LOAD_BANK1)) &&
      !(dev_sel == coco_bus_pkg::dev_cart && load_idx == `COCO_LOAD_CART))
    else $error("download index %0d hits the array the cpu is accessing", load_idx);

endmodule

`default_nettype wire

/* rtl/bus_decode.sv */
// combinational address decode into device select, rom bank and array offsets
`timescale 1ns/1ns
`default_nettype none

`include "coco_bus_cfg.svh"

module bus_decode (
  input  wire logic                  dragon64,      // static mode pin
  input  wire coco_bus_pkg::addr_t   bus_addr,
  input  wire logic                  rom_bank_sel,  // from pia1 port b
  output coco_bus_pkg::dev_sel_t     dev_sel,
  output logic                       rom_bank,      // 1 picks the second basic bank
  output coco_bus_pkg::ram_addr_t    ram_addr,
  output coco_bus_pkg::rom_addr_t    rom_addr
);

  logic acia_hit;  // upper half of each pia0 quad on the dragon 64

  assign acia_hit = dragon64 & bus_addr[`COCO_ACIA_SEL_BIT];

  // walk the map from the bottom up
  always_comb
  begin
    if (bus_addr < `COCO_ROM_BASE)
    begin
      dev_sel = coco_bus_pkg::dev_ram;          // 0000-7fff
    end
    else if (bus_addr < `COCO_CART_BASE)
    begin
      dev_sel = coco_bus_pkg::dev_rom;          // ext basic and colour basic together
    end
    else if (bus_addr < `COCO_PIA0_BASE)
    begin
      dev_sel = coco_bus_pkg::dev_cart;         // c000-feff
    end
    else if (bus_addr < `COCO_PIA1_BASE)
    begin
      // ff00-ff1f, dragon 64 hangs the serial stub off address bit 2
      if (acia_hit)
        dev_sel = coco_bus_pkg::dev_acia;
      else
        dev_sel = coco_bus_pkg::dev_pia0;
    end
    else if (bus_addr < `COCO_DISK_BASE)
    begin
      dev_sel = coco_bus_pkg::dev_pia1;         // ff20-ff3f, mirrored every 4
    end
    else if (bus_addr < `COCO_NONE_BASE)
    begin
      dev_sel = coco_bus_pkg::dev_io;           // ff40-ff5f
    end
    else
    begin
      dev_sel = coco_bus_pkg::dev_none;
    end
  end

  // 8000 -> 0000 and a000 -> 2000, so the two 8k windows form one 16k bank
  // c000 -> 0000 for the cartridge, the same low bits serve both
  assign rom_addr = bus_addr[`COCO_ROM_AW-1:0];
  assign ram_addr = bus_addr[`COCO_RAM_AW-1:0];

  // coco has a single bank, the pia line only counts on the dragon 64
  assign rom_bank = dragon64 & rom_bank_sel;

endmodule

`default_nettype wire

/* rtl/coco_bus_pkg.sv */
// shared bus types and the device select enum, referenced by scoped name from rtl and testbench
`default_nettype none

`include "coco_bus_cfg.svh"

package coco_bus_pkg;

  // cpu side
  typedef logic [`COCO_ADDR_W-1:0] addr_t;   // full 64k address
  typedef logic [`COCO_DATA_W-1:0] data_t;   // one bus byte

  // array offsets
  typedef logic [`COCO_RAM_AW-1:0] ram_addr_t;  // word address into the 32k ram
  typedef logic [`COCO_ROM_AW-1:0] rom_addr_t;  // offset into a rom bank or the cartridge

  // download port
  typedef logic [`COCO_LOAD_W-1:0] load_idx_t;  // which array a download byte goes to

  // device a request lands on
  // ram, rom and cart come out of the arrays
  // pia1 is the only live peripheral, acia is a status stub
  // pia0 and io have no function left and read as unmapped
  typedef enum logic [2:0] {
    dev_ram  = 3'd0,
    dev_rom  = 3'd1,  // both basic windows, bank picked separately
    dev_cart = 3'd2,
    dev_pia0 = 3'd3,
    dev_pia1 = 3'd4,
    dev_acia = 3'd5,  // dragon 64 only
    dev_io   = 3'd6,  // disk i/o window
    dev_none = 3'd7   // ff60 and up
  } dev_sel_t;

endpackage

`default_nettype wire

/* rtl/coco_bus_cfg.svh */
// bus widths, memory map bases and stub values, included by the rtl and the testbench
`ifndef COCO_BUS_CFG_SVH
`define COCO_BUS_CFG_SVH

// widths
`define COCO_ADDR_W         16        // cpu address
`define COCO_DATA_W         8         // bus byte
`define COCO_RAM_AW         15        // 32k ram
`define COCO_ROM_AW         14        // one 16k rom bank, or the cartridge
`define COCO_LOAD_W         2         // download index

// memory map, each base is the first address of its window
`define COCO_ROM_BASE       16'h8000  // extended basic, then colour basic at a000
`define COCO_CART_BASE      16'hc000  // cartridge up to feff
`define COCO_PIA0_BASE      16'hff00
`define COCO_PIA1_BASE      16'hff20
`define COCO_DISK_BASE      16'hff40
`define COCO_NONE_BASE      16'hff60  // nothing from here up
`define COCO_ACIA_SEL_BIT   2         // dragon 64 splits the pia0 window on this bit

// read path
`define COCO_READ_LATENCY   2         // request edge to result edge, in cycles
`define COCO_UNMAPPED_DATA  8'hff
`define COCO_ACIA_STATUS    8'h10     // transmit empty
`define COCO_PORTB_IN_D64   8'h01     // pin 0 held high on the dragon 64

// download targets
`define COCO_LOAD_BANK1     2'd0
`define COCO_LOAD_BANK2     2'd1
`define COCO_LOAD_CART      2'd2

`endif
